// File: Bender.yml
package:
  name: vita_tx_core

sources:
  - files:
      - hdl/vita_tx_pkg.sv
      - hdl/vita_time_counter.sv
      - hdl/vita_tx_deframer.sv
      - hdl/sample_fifo.sv
      - hdl/vita_tx_control.sv
      - hdl/dsp_core_tx.sv
      - hdl/vita_tx_core.sv
  - target: test
    files:
      - tests/tb_vita_tx_core.sv

// File: flist.f
hdl/vita_tx_pkg.sv
hdl/vita_time_counter.sv
hdl/vita_tx_deframer.sv
hdl/sample_fifo.sv
hdl/vita_tx_control.sv
hdl/dsp_core_tx.sv
hdl/vita_tx_core.sv
tests/tb_vita_tx_core.sv

// File: hdl/dsp_core_tx.sv
////////////////////
// TX DSP output stage
// Interpolation strobe and DAC registers
////////////////////

`timescale 1ns/100ps

module dsp_core_tx (
   input  logic                   dsp_clk,
   input  logic                   wb_rst,
   input  logic                   set_stb_i,
   input  vita_tx_pkg::set_addr_t set_addr_i,
   input  vita_tx_pkg::set_data_t set_data_i,
   input  logic                   run_i,
   input  vita_tx_pkg::sample_t   sample_i,
   output logic                   strobe_o,
   output vita_tx_pkg::dac_word_t dac_a_o,
   output vita_tx_pkg::dac_word_t dac_b_o
);

   vita_tx_pkg::interp_t interp;
   vita_tx_pkg::interp_t interp_cnt;

   // First run cycle always strobes since the counter idles at zero
   assign strobe_o = run_i && (interp_cnt == '0);

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         interp <= '0;
      end else if (set_stb_i && (set_addr_i == vita_tx_pkg::SR_TX_DSP)) begin
         interp <= set_data_i[vita_tx_pkg::INTERP_W-1:0];
      end
   end

   // One strobe every interp+1 cycles
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         interp_cnt <= '0;
      end else if (!run_i) begin
         interp_cnt <= '0;
      end else if (strobe_o) begin
         interp_cnt <= interp;
      end else begin
         interp_cnt <= interp_cnt - 1'b1;
      end
   end

   ////////////////////
   // DAC words, I on A and Q on B
   always_ff @(posedge dsp_clk) begin
      if (wb_rst || !run_i) begin
         dac_a_o <= '0;
         dac_b_o <= '0;
      end else if (strobe_o) begin
         dac_a_o <= sample_i[vita_tx_pkg::SAMPLE_W-1 -: vita_tx_pkg::DAC_W];
         dac_b_o <= sample_i[vita_tx_pkg::DAC_W-1:0];
      end
   end

endmodule

// File: hdl/sample_fifo.sv
////////////////////
// Sample item FIFO
// Circular buffer with valid/ready on both sides
////////////////////

`timescale 1ns/100ps

module sample_fifo #(
   parameter int DEPTH_LOG2 = vita_tx_pkg::SAMPLE_FIFO_DEPTH_LOG2
) (
   input  logic               dsp_clk,
   input  logic               wb_rst,
   input  logic               in_valid_i,
   input  vita_tx_pkg::item_t in_item_i,
   output logic               in_ready_o,
   output logic               out_valid_o,
   output vita_tx_pkg::item_t out_item_o,
   input  logic               out_ready_i
);

   localparam logic [DEPTH_LOG2:0] DEPTH = 1 << DEPTH_LOG2;

   vita_tx_pkg::item_t    mem [DEPTH];
   logic [DEPTH_LOG2-1:0] wr_ptr;
   logic [DEPTH_LOG2-1:0] rd_ptr;
   logic [DEPTH_LOG2:0]   count;
   logic [DEPTH_LOG2:0]   count_nxt;
   logic                  push;
   logic                  pop;

   assign push        = in_valid_i && in_ready_o;
   assign pop         = out_valid_o && out_ready_i;
   assign out_valid_o = (count != '0);
   assign out_item_o  = mem[rd_ptr];

   always_comb begin
      count_nxt = count;
      if (push && !pop) begin
         count_nxt = count + 1'b1;
      end else if (pop && !push) begin
         count_nxt = count - 1'b1;
      end
   end

   // Ready is registered so it stays low through reset
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         count      <= '0;
         in_ready_o <= 1'b0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         count      <= count_nxt;
         in_ready_o <= (count_nxt != DEPTH);
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (push) begin
         mem[wr_ptr] <= in_item_i;
      end
   end

endmodule

// File: hdl/vita_time_counter.sv
////////////////////
// VITA time counter
// Free-running 64-bit time, loaded from the settings bus
////////////////////

`timescale 1ns/100ps

module vita_time_counter (
   input  logic                   dsp_clk,
   input  logic                   wb_rst,
   input  logic                   set_stb_i,
   input  vita_tx_pkg::set_addr_t set_addr_i,
   input  vita_tx_pkg::set_data_t set_data_i,
   output vita_tx_pkg::time_t     vita_time_o
);

   vita_tx_pkg::set_data_t time_hi;
   logic                   wr_hi;
   logic                   wr_lo;

   assign wr_hi = set_stb_i && (set_addr_i == vita_tx_pkg::SR_TIME64);
   assign wr_lo = set_stb_i && (set_addr_i == vita_tx_pkg::SR_TIME64 + 8'd1);

   // High word is held until the low word write loads both
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         time_hi <= '0;
      end else if (wr_hi) begin
         time_hi <= set_data_i;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         vita_time_o <= '0;
      end else if (wr_lo) begin
         vita_time_o <= {time_hi, set_data_i};
      end else begin
         vita_time_o <= vita_time_o + 1'b1;
      end
   end

endmodule

// File: hdl/vita_tx_control.sv
////////////////////
// VITA TX control
// Holds timed bursts, feeds samples on strobe, flags underrun
////////////////////

`timescale 1ns/100ps

module vita_tx_control (
   input  logic                 dsp_clk,
   input  logic                 wb_rst,
   input  vita_tx_pkg::time_t   vita_time_i,
   input  logic                 item_valid_i,
   input  vita_tx_pkg::item_t   item_i,
   output logic                 item_ready_o,
   input  logic                 strobe_i,
   output logic                 run_o,
   output vita_tx_pkg::sample_t sample_o,
   output logic                 underrun_o
);

   vita_tx_pkg::tx_state_t state;
   vita_tx_pkg::tx_state_t state_nxt;
   vita_tx_pkg::time_t     item_time;
   logic                   item_has_time;
   logic                   item_sob;
   logic                   item_eob;
   logic                   pop;
   logic                   underrun_det;

   // Head of FIFO
   assign item_time     = item_i[vita_tx_pkg::ITEM_TIME_LSB +: vita_tx_pkg::TIME_W];
   assign item_has_time = item_i[vita_tx_pkg::ITEM_HAS_TIME_BIT];
   assign item_sob      = item_i[vita_tx_pkg::ITEM_SOB_BIT];
   assign item_eob      = item_i[vita_tx_pkg::ITEM_EOB_BIT];

   // Zero when empty so an underrun strobe puts silence on the DACs
   assign sample_o = item_valid_i ?
                     item_i[vita_tx_pkg::ITEM_SAMPLE_LSB +: vita_tx_pkg::SAMPLE_W] : '0;

   assign run_o        = (state == vita_tx_pkg::RUN);
   assign item_ready_o = pop;

   ////////////////////
   // Burst FSM
   always_comb begin
      state_nxt    = state;
      pop          = 1'b0;
      underrun_det = 1'b0;
      case (state)
         vita_tx_pkg::IDLE: begin
            if (item_valid_i) begin
               if (!item_sob) begin
                  // Leftover item outside a burst
                  pop = 1'b1;
               end else if (item_has_time) begin
                  state_nxt = vita_tx_pkg::WAIT_TIME;
               end else begin
                  state_nxt = vita_tx_pkg::RUN;
               end
            end
         end
         vita_tx_pkg::WAIT_TIME: begin
            if (vita_time_i == item_time) begin
               state_nxt = vita_tx_pkg::RUN;
            end
         end
         vita_tx_pkg::RUN: begin
            if (strobe_i) begin
               if (item_valid_i) begin
                  pop = 1'b1;
                  if (item_eob) begin
                     state_nxt = vita_tx_pkg::IDLE;
                  end
               end else begin
                  underrun_det = 1'b1;
                  state_nxt    = vita_tx_pkg::FLUSH;
               end
            end
         end
         vita_tx_pkg::FLUSH: begin
            // Drain the rest of the broken burst
            if (item_valid_i) begin
               pop = 1'b1;
               if (item_eob) begin
                  state_nxt = vita_tx_pkg::IDLE;
               end
            end
         end
         default: begin
            state_nxt = vita_tx_pkg::IDLE;
         end
      endcase
   end

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         state      <= vita_tx_pkg::IDLE;
         underrun_o <= 1'b0;
      end else begin
         state      <= state_nxt;
         underrun_o <= underrun_det;
      end
   end

endmodule

// File: hdl/vita_tx_core.sv
////////////////////
// VITA transmit core
// Deframer, sample FIFO, TX control, DSP output and time
////////////////////

`timescale 1ns/100ps

module vita_tx_core (
   input  logic                     dsp_clk,
   input  logic                     wb_rst,
   input  logic                     set_stb_i,
   input  vita_tx_pkg::set_addr_t   set_addr_i,
   input  vita_tx_pkg::set_data_t   set_data_i,
   input  logic                     line_valid_i,
   input  vita_tx_pkg::line_flags_t line_flags_i,
   input  vita_tx_pkg::line_data_t  line_data_i,
   output logic                     line_ready_o,
   output vita_tx_pkg::dac_word_t   dac_a_o,
   output vita_tx_pkg::dac_word_t   dac_b_o,
   output logic                     run_o,
   output logic                     underrun_o,
   output vita_tx_pkg::time_t       vita_time_o
);

   logic                 dfr_valid;
   logic                 dfr_ready;
   vita_tx_pkg::item_t   dfr_item;
   logic                 fifo_valid;
   logic                 fifo_ready;
   vita_tx_pkg::item_t   fifo_item;
   logic                 tx_strobe;
   vita_tx_pkg::sample_t tx_sample;

   vita_time_counter vita_time_counter_inst (
      .dsp_clk     (dsp_clk),
      .wb_rst      (wb_rst),
      .set_stb_i   (set_stb_i),
      .set_addr_i  (set_addr_i),
      .set_data_i  (set_data_i),
      .vita_time_o (vita_time_o)
   );

   ////////////////////
   // Producer, buffer, consumer
   vita_tx_deframer vita_tx_deframer_inst (
      .dsp_clk      (dsp_clk),
      .wb_rst       (wb_rst),
      .line_valid_i (line_valid_i),
      .line_flags_i (line_flags_i),
      .line_data_i  (line_data_i),
      .line_ready_o (line_ready_o),
      .item_valid_o (dfr_valid),
      .item_o       (dfr_item),
      .item_ready_i (dfr_ready)
   );

   sample_fifo sample_fifo_inst (
      .dsp_clk     (dsp_clk),
      .wb_rst      (wb_rst),
      .in_valid_i  (dfr_valid),
      .in_item_i   (dfr_item),
      .in_ready_o  (dfr_ready),
      .out_valid_o (fifo_valid),
      .out_item_o  (fifo_item),
      .out_ready_i (fifo_ready)
   );

   vita_tx_control vita_tx_control_inst (
      .dsp_clk      (dsp_clk),
      .wb_rst       (wb_rst),
      .vita_time_i  (vita_time_o),
      .item_valid_i (fifo_valid),
      .item_i       (fifo_item),
      .item_ready_o (fifo_ready),
      .strobe_i     (tx_strobe),
      .run_o        (run_o),
      .sample_o     (tx_sample),
      .underrun_o   (underrun_o)
   );

   dsp_core_tx dsp_core_tx_inst (
      .dsp_clk    (dsp_clk),
      .wb_rst     (wb_rst),
      .set_stb_i  (set_stb_i),
      .set_addr_i (set_addr_i),
      .set_data_i (set_data_i),
      .run_i      (run_o),
      .sample_i   (tx_sample),
      .strobe_o   (tx_strobe),
      .dac_a_o    (dac_a_o),
      .dac_b_o    (dac_b_o)
   );

endmodule

// File: hdl/vita_tx_deframer.sv
////////////////////
// VITA TX deframer
// Splits packet lines into timestamped sample items
////////////////////

`timescale 1ns/100ps

module vita_tx_deframer (
   input  logic                     dsp_clk,
   input  logic                     wb_rst,
   input  logic                     line_valid_i,
   input  vita_tx_pkg::line_flags_t line_flags_i,
   input  vita_tx_pkg::line_data_t  line_data_i,
   output logic                     line_ready_o,
   output logic                     item_valid_o,
   output vita_tx_pkg::item_t       item_o,
   input  logic                     item_ready_i
);

   vita_tx_pkg::deframe_state_t state;
   vita_tx_pkg::deframe_state_t state_nxt;
   vita_tx_pkg::time_t          burst_time;
   logic                        has_time;
   logic                        first_sample;
   logic                        line_acc;
   logic                        is_sop;
   logic                        is_eop;

   // Items leave in the cycle their line arrives, so FIFO ready is line ready
   assign line_ready_o = item_ready_i;
   assign line_acc     = line_valid_i && line_ready_o;
   assign is_sop       = line_flags_i[vita_tx_pkg::FLAG_SOP];
   assign is_eop       = line_flags_i[vita_tx_pkg::FLAG_EOP];

   assign item_valid_o = line_valid_i && !is_sop && (state == vita_tx_pkg::SAMPLES);

   always_comb begin
      item_o = '0;
      item_o[vita_tx_pkg::ITEM_SAMPLE_LSB +: vita_tx_pkg::SAMPLE_W] = line_data_i;
      item_o[vita_tx_pkg::ITEM_TIME_LSB +: vita_tx_pkg::TIME_W]     = burst_time;
      item_o[vita_tx_pkg::ITEM_HAS_TIME_BIT] = has_time;
      item_o[vita_tx_pkg::ITEM_SOB_BIT]      = first_sample;
      item_o[vita_tx_pkg::ITEM_EOB_BIT]      = is_eop;
   end

   ////////////////////
   // Packet parser
   always_comb begin
      state_nxt = state;
      // Any start of packet resyncs onto a header
      if (is_sop) begin
         if (line_data_i[vita_tx_pkg::HDR_HAS_TIME_BIT]) begin
            state_nxt = vita_tx_pkg::TIME_HI;
         end else begin
            state_nxt = vita_tx_pkg::SAMPLES;
         end
      end else begin
         case (state)
            vita_tx_pkg::TIME_HI: state_nxt = vita_tx_pkg::TIME_LO;
            vita_tx_pkg::TIME_LO: state_nxt = vita_tx_pkg::SAMPLES;
            default:              state_nxt = state;
         endcase
      end
      if (is_eop) begin
         state_nxt = vita_tx_pkg::HEADER;
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         state        <= vita_tx_pkg::HEADER;
         has_time     <= 1'b0;
         first_sample <= 1'b0;
      end else if (line_acc) begin
         state <= state_nxt;
         if (is_sop) begin
            has_time     <= line_data_i[vita_tx_pkg::HDR_HAS_TIME_BIT];
            first_sample <= 1'b1;
         end else if (state == vita_tx_pkg::SAMPLES) begin
            first_sample <= 1'b0;
         end
      end
   end

   // Burst time words
   always_ff @(posedge dsp_clk) begin
      if (line_acc && !is_sop) begin
         if (state == vita_tx_pkg::TIME_HI) begin
            burst_time <= {line_data_i, burst_time[31:0]};
         end else if (state == vita_tx_pkg::TIME_LO) begin
            burst_time <= {burst_time[63:32], line_data_i};
         end
      end
   end

endmodule

// File: hdl/vita_tx_pkg.sv
////////////////////
// VITA transmit path shared definitions
// Widths, item layout, packet flags and settings addresses
////////////////////

package vita_tx_pkg;

   ////////////////////
   // Widths
   localparam int TIME_W      = 64;
   localparam int SAMPLE_W    = 32;
   localparam int DAC_W       = 16;
   localparam int SET_ADDR_W  = 8;
   localparam int SET_DATA_W  = 32;
   localparam int LINE_DATA_W = 32;
   localparam int LINE_FLAG_W = 4;
   localparam int INTERP_W    = 16;

   typedef logic [TIME_W-1:0]      time_t;
   // I in the upper half, Q in the lower half
   typedef logic [SAMPLE_W-1:0]    sample_t;
   typedef logic [DAC_W-1:0]       dac_word_t;
   typedef logic [SET_ADDR_W-1:0]  set_addr_t;
   typedef logic [SET_DATA_W-1:0]  set_data_t;
   typedef logic [LINE_DATA_W-1:0] line_data_t;
   typedef logic [LINE_FLAG_W-1:0] line_flags_t;
   typedef logic [INTERP_W-1:0]    interp_t;

   ////////////////////
   // Packet line flags and header bits
   localparam int FLAG_SOP = 0;
   localparam int FLAG_EOP = 1;
   // Two time words follow the header when set
   localparam int HDR_HAS_TIME_BIT = 20;

   ////////////////////
   // Settings bus bases
   // Time: +0 high word, +1 low word and load
   localparam set_addr_t SR_TIME64 = 8'd192;
   // TX DSP: +0 interpolation count
   localparam set_addr_t SR_TX_DSP = 8'd208;

   ////////////////////
   // Sample item layout, markers on top
   localparam int ITEM_SAMPLE_LSB   = 0;
   localparam int ITEM_TIME_LSB     = ITEM_SAMPLE_LSB + SAMPLE_W;
   localparam int ITEM_HAS_TIME_BIT = ITEM_TIME_LSB + TIME_W;
   localparam int ITEM_SOB_BIT      = ITEM_HAS_TIME_BIT + 1;
   localparam int ITEM_EOB_BIT      = ITEM_SOB_BIT + 1;
   localparam int ITEM_W            = ITEM_EOB_BIT + 1;

   typedef logic [ITEM_W-1:0] item_t;

   localparam int SAMPLE_FIFO_DEPTH_LOG2 = 4;

   // Deframer and transmit control FSMs
   typedef enum logic [1:0] {HEADER, TIME_HI, TIME_LO, SAMPLES} deframe_state_t;
   typedef enum logic [1:0] {IDLE, WAIT_TIME, RUN, FLUSH} tx_state_t;

endpackage

// File: tests/tb_vita_tx_core.sv
////////////////////
// VITA transmit core testbench
// Trace-driven stimulus, time model and DAC burst checks
////////////////////

`timescale 1ns/100ps

module tb_vita_tx_core;

   localparam int CLK_PERIOD = 4;
   localparam int MAX_REC    = 64;

   logic                     dsp_clk = 1'b0;
   logic                     wb_rst;
   logic                     set_stb_i;
   vita_tx_pkg::set_addr_t   set_addr_i;
   vita_tx_pkg::set_data_t   set_data_i;
   logic                     line_valid_i;
   vita_tx_pkg::line_flags_t line_flags_i;
   vita_tx_pkg::line_data_t  line_data_i;
   logic                     line_ready_o;
   vita_tx_pkg::dac_word_t   dac_a_o;
   vita_tx_pkg::dac_word_t   dac_b_o;
   logic                     run_o;
   logic                     underrun_o;
   vita_tx_pkg::time_t       vita_time_o;

   // Trace records as a kind letter and up to seven hex fields
   logic [7:0]  rec_kind [MAX_REC];
   logic [63:0] rec_f    [MAX_REC][7];
   int          n_rec = 0;
   logic        trace_loaded = 1'b0;
   logic        bursts_done = 1'b0;
   logic        saw_backpressure = 1'b0;
   logic [31:0] rng = 32'h4e52_96e1;

   // First sample line of an untimed packet
   logic        sob_pending = 1'b0;
   time         sob_time = 0;

   // Time reference
   vita_tx_pkg::time_t     exp_time = '0;
   vita_tx_pkg::set_data_t time_hi_model = '0;
   logic                   model_live = 1'b0;

   vita_tx_core vita_tx_core_inst (.*);

   initial begin
      forever #(CLK_PERIOD / 2) dsp_clk = ~dsp_clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic compare_value(input string name, input logic [63:0] exp, input logic [63:0] act);
      assert (act === exp) else begin
         $display("Mismatch %s: expected %h, actual %h", name, exp, act);
         $display("** FAIL **");
         $fatal(1);
      end
   endtask

   task automatic require_true(input logic cond, input string what);
      assert (cond === 1'b1) else begin
         $display("%s", what);
         $display("** FAIL **");
         $fatal(1);
      end
   endtask

   task automatic load_trace();
      int               fd;
      int               code;
      int               nf;
      logic [7:0]       kind;
      logic [63:0]      val;
      logic [8*128-1:0] skip_line;
      fd = $fopen("tests/vita_tx_trace.txt", "r");
      require_true(fd != 0, "Trace file tests/vita_tx_trace.txt could not be opened");
      while ($fscanf(fd, " %c", kind) == 1) begin
         if (kind == "#") begin
            code = $fgets(skip_line, fd);
         end else begin
            case (kind)
               "S", "L": nf = 2;
               "R":      nf = 4;
               "G":      nf = 1;
               "E":      nf = 7;
               default:  nf = -1;
            endcase
            require_true(nf > 0, "Trace file holds an unknown record kind");
            require_true(n_rec < MAX_REC, "Trace file holds too many records");
            rec_kind[n_rec] = kind;
            for (int i = 0; i < nf; i++) begin
               code = $fscanf(fd, "%h", val);
               require_true(code == 1, "Trace file record is missing a field");
               rec_f[n_rec][i] = val;
            end
            n_rec++;
         end
      end
      $fclose(fd);
   endtask

   task automatic write_setting(input vita_tx_pkg::set_addr_t a, input vita_tx_pkg::set_data_t d);
      set_stb_i  = 1'b1;
      set_addr_i = a;
      set_data_i = d;
      @(negedge dsp_clk);
      set_stb_i  = 1'b0;
   endtask

   // One line with handshake and a short random gap after it
   task automatic send_line(input vita_tx_pkg::line_flags_t f, input vita_tx_pkg::line_data_t d);
      int gap;
      line_valid_i = 1'b1;
      line_flags_i = f;
      line_data_i  = d;
      while (!line_ready_o) begin
         saw_backpressure = 1'b1;
         @(negedge dsp_clk);
      end
      @(negedge dsp_clk);
      if (sob_pending) begin
         sob_time = $time;
      end
      sob_pending = f[vita_tx_pkg::FLAG_SOP] && !d[vita_tx_pkg::HDR_HAS_TIME_BIT];
      line_valid_i = 1'b0;
      rng = lcg_next(rng);
      gap = rng[16];
      repeat (gap) @(negedge dsp_clk);
   endtask

   // Inside a burst underrun stays low on every cycle
   task automatic step_no_underrun(input int cycles, input string tag);
      for (int c = 0; c < cycles; c++) begin
         @(negedge dsp_clk);
         compare_value($sformatf("%s underrun", tag), 0, underrun_o);
      end
   endtask

   ////////////////////
   // Burst monitor
   task automatic watch_burst(input int r, input int b);
      int          interp;
      int          n;
      logic [31:0] smp;
      interp = int'(rec_f[r][2]);
      n      = int'(rec_f[r][3]);
      @(negedge dsp_clk);
      // Silence until the burst starts
      while (!run_o) begin
         compare_value($sformatf("burst %0d idle dac_a", b), 0, dac_a_o);
         compare_value($sformatf("burst %0d idle dac_b", b), 0, dac_b_o);
         compare_value($sformatf("burst %0d idle underrun", b), 0, underrun_o);
         @(negedge dsp_clk);
      end
      if (rec_f[r][0][0]) begin
         compare_value($sformatf("burst %0d start time", b), rec_f[r][1] + 1, vita_time_o);
      end else begin
         // FIFO shows the item one cycle after the line, run follows one cycle later
         compare_value($sformatf("burst %0d start after first item", b),
                       sob_time + CLK_PERIOD, $time);
      end
      for (int k = 0; k < n; k++) begin
         step_no_underrun((k == 0) ? 1 : interp + 1, $sformatf("burst %0d sample %0d", b, k));
         smp = rec_f[r][5][31:0] + k * rec_f[r][6][31:0];
         compare_value($sformatf("burst %0d sample %0d dac_a", b, k), smp[31:16], dac_a_o);
         compare_value($sformatf("burst %0d sample %0d dac_b", b, k), smp[15:0], dac_b_o);
         compare_value($sformatf("burst %0d sample %0d run", b, k),
                       (k < n - 1) || rec_f[r][4][0], run_o);
      end
      if (rec_f[r][4][0]) begin
         step_no_underrun(interp, $sformatf("burst %0d before underrun", b));
         @(negedge dsp_clk);
         compare_value($sformatf("burst %0d underrun pulse", b), 1, underrun_o);
         compare_value($sformatf("burst %0d run after underrun", b), 0, run_o);
         compare_value($sformatf("burst %0d dac_a after underrun", b), 0, dac_a_o);
         compare_value($sformatf("burst %0d dac_b after underrun", b), 0, dac_b_o);
      end
   endtask

   initial begin
      int b;
      b = 0;
      @(posedge dsp_clk);
      wait (trace_loaded);
      for (int r = 0; r < n_rec; r++) begin
         if (rec_kind[r] == "E") begin
            watch_burst(r, b);
            b++;
         end
      end
      bursts_done = 1'b1;
   end

   // Loaded value plus cycles since the load
   always @(posedge dsp_clk) begin
      model_live = 1'b1;
      if (wb_rst) begin
         exp_time      = '0;
         time_hi_model = '0;
      end else if (set_stb_i && (set_addr_i == vita_tx_pkg::SR_TIME64 + 8'd1)) begin
         exp_time = {time_hi_model, set_data_i};
      end else begin
         exp_time = exp_time + 1'b1;
         if (set_stb_i && (set_addr_i == vita_tx_pkg::SR_TIME64)) begin
            time_hi_model = set_data_i;
         end
      end
   end

   always @(negedge dsp_clk) begin
      if (model_live) begin
         compare_value("vita time", exp_time, vita_time_o);
      end
   end

   initial begin
      wait (trace_loaded);
      #(n_rec * 64 * CLK_PERIOD);
      $display("Timeout after %0d cycles with bursts still pending", n_rec * 64);
      $display("** FAIL **");
      $fatal(1);
   end

   ////////////////////
   // Stimulus
   initial begin
      int cnt;
      wb_rst       = 1'b1;
      set_stb_i    = 1'b0;
      set_addr_i   = '0;
      set_data_i   = '0;
      line_valid_i = 1'b0;
      line_flags_i = '0;
      line_data_i  = '0;
      load_trace();
      trace_loaded = 1'b1;
      @(posedge dsp_clk);
      repeat (8) begin
         @(negedge dsp_clk);
         compare_value("line_ready in reset", 0, line_ready_o);
      end
      wb_rst = 1'b0;
      @(negedge dsp_clk);
      compare_value("line_ready after reset", 1, line_ready_o);
      for (int r = 0; r < n_rec; r++) begin
         cnt = int'(rec_f[r][1]);
         case (rec_kind[r])
            "S": write_setting(rec_f[r][0][7:0], rec_f[r][1][31:0]);
            "L": send_line(rec_f[r][0][3:0], rec_f[r][1][31:0]);
            "R": begin
               for (int k = 0; k < cnt; k++) begin
                  send_line((k == cnt - 1) ? rec_f[r][0][3:0] : 4'h0,
                            rec_f[r][2][31:0] + k * rec_f[r][3][31:0]);
               end
            end
            "G": repeat (int'(rec_f[r][0])) @(negedge dsp_clk);
            default: ;
         endcase
      end
      wait (bursts_done);
      repeat (4) @(negedge dsp_clk);
      assert (saw_backpressure) begin
         $display("** PASS **");
         $finish;
      end else begin
         $display("line_ready_o never dropped during the long burst");
         $display("** FAIL **");
         $fatal(1);
      end
   end

endmodule

// File: tests/vita_tx_trace.txt
# Records, all fields hex: S addr data | L flags data | G idle_cycles
# R last_flags count first step | E timed time interp count underrun first step
S c0 00000001
S c1 fffffff0
S d0 00000002
E 1 0000000200000030 2 4 0 11110001 00010001
L 1 00100000
L 0 00000002
L 0 00000030
R 2 4 11110001 00010001
G 50
E 0 0 2 3 0 20000001 00030003
L 1 00000000
R 2 3 20000001 00030003
G 10
E 0 0 2 3 1 30000001 00010001
L 1 00000000
R 0 3 30000001 00010001
G 1e
R 2 3 30000004 00010001
E 0 0 2 2 0 40000001 00010002
L 1 00000000
R 2 2 40000001 00010002
G 10
S d0 00000007
E 0 0 7 18 0 50000001 00010001
L 1 00000000
R 2 18 50000001 00010001
G 8
